// File: filelist.f
+incdir+verilog
verilog/axi_xbar_pkg.sv
verilog/axi_write_router.sv
verilog/axi_read_router.sv
verilog/axi_xbar_top.sv
sim/axi_xbar_properties.sv
sim/axi_xbar_tb.sv

// File: run.sh
#!/bin/sh
# builds the router testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module axi_xbar_tb -f filelist.f -o axi_xbar_sim \
    && ./obj_dir/axi_xbar_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && exit 1
exit 0

// File: sim/axi_xbar_properties.sv
`timescale 1ns/10ps
`include "axi_xbar_defines.svh"

module axi_xbar_properties (
    input logic                           clk,
    input logic                           rst,
    input logic [`AXI_XBAR_SLAVE_NUM-1:0] s_aw_valid,
    input logic [`AXI_XBAR_SLAVE_NUM-1:0] s_ar_valid,
    input logic [`AXI_XBAR_SLAVE_NUM-1:0] s_b_ready,
    input logic [`AXI_XBAR_SLAVE_NUM-1:0] s_r_ready,
    input logic                           m_aw_ready,
    input logic                           m_w_ready,
    input logic                           m_b_valid,
    input logic                           m_ar_ready,
    input logic                           m_r_valid
);

    // only one slave per path is ever driven
    a_aw_valid_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(s_aw_valid))
        else $error("aw_valid is high on more than one slave");
    a_ar_valid_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(s_ar_valid))
        else $error("ar_valid is high on more than one slave");
    a_b_ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(s_b_ready))
        else $error("b_ready is high on more than one slave");
    a_r_ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(s_r_ready))
        else $error("r_ready is high on more than one slave");

    // master side comes out of reset quiet
    a_master_quiet: assert property (@(posedge clk)
        rst |=> !(m_b_valid || m_r_valid || m_aw_ready || m_w_ready || m_ar_ready))
        else $error("master valid or ready high in the cycle after reset");

endmodule

bind axi_xbar_top axi_xbar_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .s_aw_valid (s_aw_valid),
    .s_ar_valid (s_ar_valid),
    .s_b_ready  (s_b_ready),
    .s_r_ready  (s_r_ready),
    .m_aw_ready (m_aw_ready),
    .m_w_ready  (m_w_ready),
    .m_b_valid  (m_b_valid),
    .m_ar_ready (m_ar_ready),
    .m_r_valid  (m_r_valid)
);

// File: sim/axi_xbar_tb.sv
`timescale 1ns/10ps
`include "axi_xbar_defines.svh"

module axi_xbar_tb import axi_xbar_pkg::*; ();

    localparam int NS          = `AXI_XBAR_SLAVE_NUM;
    localparam int NUM_TESTS   = 26;
    localparam int CYCLE_LIMIT = NUM_TESTS + 20;
    localparam int IDLE_IDX    = 3;

    logic       clk;
    logic       rst;
    slave_sel_t wr_sel;
    slave_sel_t rd_sel;

    axi_ax_t m_aw;
    logic    m_aw_valid;
    logic    m_aw_ready;
    axi_w_t  m_w;
    logic    m_w_valid;
    logic    m_w_ready;
    axi_b_t  m_b;
    logic    m_b_valid;
    logic    m_b_ready;
    axi_ax_t m_ar;
    logic    m_ar_valid;
    logic    m_ar_ready;
    axi_r_t  m_r;
    logic    m_r_valid;
    logic    m_r_ready;

    axi_ax_t [NS-1:0] s_aw;
    logic    [NS-1:0] s_aw_valid;
    logic    [NS-1:0] s_aw_ready;
    axi_w_t  [NS-1:0] s_w;
    logic    [NS-1:0] s_w_valid;
    logic    [NS-1:0] s_w_ready;
    axi_b_t  [NS-1:0] s_b;
    logic    [NS-1:0] s_b_valid;
    logic    [NS-1:0] s_b_ready;
    axi_ax_t [NS-1:0] s_ar;
    logic    [NS-1:0] s_ar_valid;
    logic    [NS-1:0] s_ar_ready;
    axi_r_t  [NS-1:0] s_r;
    logic    [NS-1:0] s_r_valid;
    logic    [NS-1:0] s_r_ready;

    // four hex words per test as wr_sel, rd_sel, write index and read index
    logic [3:0] test_mem [0:NUM_TESTS*4-1];

    int cycles = 0;
    int errors = 0;
    int test_errors = 0;
    int failed_tests = 0;

    axi_xbar_top u_dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the test sequence did not finish within %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic report_value(input string name, input logic [127:0] exp,
                                input logic [127:0] act);
        $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        errors++;
        test_errors++;
    endtask

    function automatic axi_ax_t random_ax();
        axi_ax_t ax;
        ax.id    = axi_id_t'($urandom);
        ax.addr  = {$urandom, $urandom};
        ax.len   = axi_len_t'($urandom);
        ax.size  = axi_size_t'($urandom);
        ax.burst = axi_burst_t'($urandom);
        return ax;
    endfunction

    function automatic axi_w_t random_w();
        axi_w_t w;
        w.data = {$urandom, $urandom};
        w.strb = axi_strb_t'($urandom);
        w.last = 1'($urandom);
        return w;
    endfunction

    function automatic axi_r_t random_r();
        axi_r_t r;
        r.id   = axi_id_t'($urandom);
        r.data = {$urandom, $urandom};
        r.resp = axi_resp_t'($urandom);
        r.last = 1'($urandom);
        return r;
    endfunction

    task automatic drive_random(input slave_sel_t wsel, input slave_sel_t rsel);
        wr_sel     = wsel;
        rd_sel     = rsel;
        m_aw       = random_ax();
        m_aw_valid = 1'($urandom);
        m_w        = random_w();
        m_w_valid  = 1'($urandom);
        m_b_ready  = 1'($urandom);
        m_ar       = random_ax();
        m_ar_valid = 1'($urandom);
        m_r_ready  = 1'($urandom);
        for (int j = 0; j < NS; j++) begin
            s_b[j].id   = axi_id_t'($urandom);
            s_b[j].resp = axi_resp_t'($urandom);
            s_r[j]      = random_r();
        end
        s_aw_ready = slave_sel_t'($urandom);
        s_w_ready  = slave_sel_t'($urandom);
        s_b_valid  = slave_sel_t'($urandom);
        s_ar_ready = slave_sel_t'($urandom);
        s_r_valid  = slave_sel_t'($urandom);
    endtask

    task automatic check_reset();
        if ({s_aw_valid, s_w_valid, s_b_ready, s_ar_valid, s_r_ready, m_aw_ready,
             m_w_ready, m_b_valid, m_ar_ready, m_r_valid} !== '0) begin
            report_value("valid/ready outputs", '0,
                         128'({s_aw_valid, s_w_valid, s_b_ready, s_ar_valid, s_r_ready,
                               m_aw_ready, m_w_ready, m_b_valid, m_ar_ready, m_r_valid}));
        end
        for (int j = 0; j < NS; j++) begin
            if (s_aw[j] !== '0) begin
                report_value($sformatf("s_aw[%0d]", j), '0, 128'(s_aw[j]));
            end
            if (s_w[j] !== '0) begin
                report_value($sformatf("s_w[%0d]", j), '0, 128'(s_w[j]));
            end
            if (s_ar[j] !== '0) begin
                report_value($sformatf("s_ar[%0d]", j), '0, 128'(s_ar[j]));
            end
        end
        if (m_b !== '0) begin
            report_value("m_b", '0, 128'(m_b));
        end
        if (m_r !== '0) begin
            report_value("m_r", '0, 128'(m_r));
        end
    endtask

    // wk is the slave that should carry the write path or IDLE_IDX for none
    task automatic check_write(input int wk);
        slave_idx_t k;
        logic       hit;
        axi_ax_t    exp_aw;
        axi_w_t     exp_w;
        axi_b_t     exp_b;
        logic       exp_bit;
        hit = (wk != IDLE_IDX);
        k   = hit ? slave_idx_t'(wk) : '0;
        for (int j = 0; j < NS; j++) begin
            exp_aw = (j == wk) ? m_aw : '0;
            if (s_aw[j] !== exp_aw) begin
                report_value($sformatf("s_aw[%0d]", j), 128'(exp_aw), 128'(s_aw[j]));
            end
            exp_bit = (j == wk) ? m_aw_valid : 1'b0;
            if (s_aw_valid[j] !== exp_bit) begin
                report_value($sformatf("s_aw_valid[%0d]", j), 128'(exp_bit),
                             128'(s_aw_valid[j]));
            end
            exp_w = (j == wk) ? m_w : '0;
            if (s_w[j] !== exp_w) begin
                report_value($sformatf("s_w[%0d]", j), 128'(exp_w), 128'(s_w[j]));
            end
            exp_bit = (j == wk) ? m_w_valid : 1'b0;
            if (s_w_valid[j] !== exp_bit) begin
                report_value($sformatf("s_w_valid[%0d]", j), 128'(exp_bit),
                             128'(s_w_valid[j]));
            end
            exp_bit = (j == wk) ? m_b_ready : 1'b0;
            if (s_b_ready[j] !== exp_bit) begin
                report_value($sformatf("s_b_ready[%0d]", j), 128'(exp_bit),
                             128'(s_b_ready[j]));
            end
        end
        exp_bit = hit ? s_aw_ready[k] : 1'b0;
        if (m_aw_ready !== exp_bit) begin
            report_value("m_aw_ready", 128'(exp_bit), 128'(m_aw_ready));
        end
        exp_bit = hit ? s_w_ready[k] : 1'b0;
        if (m_w_ready !== exp_bit) begin
            report_value("m_w_ready", 128'(exp_bit), 128'(m_w_ready));
        end
        exp_b = hit ? s_b[k] : '0;
        if (m_b !== exp_b) begin
            report_value("m_b", 128'(exp_b), 128'(m_b));
        end
        exp_bit = hit ? s_b_valid[k] : 1'b0;
        if (m_b_valid !== exp_bit) begin
            report_value("m_b_valid", 128'(exp_bit), 128'(m_b_valid));
        end
    endtask

    task automatic check_read(input int rk);
        slave_idx_t k;
        logic       hit;
        axi_ax_t    exp_ar;
        axi_r_t     exp_r;
        logic       exp_bit;
        hit = (rk != IDLE_IDX);
        k   = hit ? slave_idx_t'(rk) : '0;
        for (int j = 0; j < NS; j++) begin
            exp_ar = (j == rk) ? m_ar : '0;
            if (s_ar[j] !== exp_ar) begin
                report_value($sformatf("s_ar[%0d]", j), 128'(exp_ar), 128'(s_ar[j]));
            end
            exp_bit = (j == rk) ? m_ar_valid : 1'b0;
            if (s_ar_valid[j] !== exp_bit) begin
                report_value($sformatf("s_ar_valid[%0d]", j), 128'(exp_bit),
                             128'(s_ar_valid[j]));
            end
            exp_bit = (j == rk) ? m_r_ready : 1'b0;
            if (s_r_ready[j] !== exp_bit) begin
                report_value($sformatf("s_r_ready[%0d]", j), 128'(exp_bit),
                             128'(s_r_ready[j]));
            end
        end
        exp_bit = hit ? s_ar_ready[k] : 1'b0;
        if (m_ar_ready !== exp_bit) begin
            report_value("m_ar_ready", 128'(exp_bit), 128'(m_ar_ready));
        end
        exp_r = hit ? s_r[k] : '0;
        if (m_r !== exp_r) begin
            report_value("m_r", 128'(exp_r), 128'(m_r));
        end
        exp_bit = hit ? s_r_valid[k] : 1'b0;
        if (m_r_valid !== exp_bit) begin
            report_value("m_r_valid", 128'(exp_bit), 128'(m_r_valid));
        end
    endtask

    initial begin
        int wk;
        int rk;
        void'($urandom(32'ha8d1_5b21));
        rst  = 1'b1;
        drive_random('0, '0);
        $readmemh("sim/axi_xbar_tests.txt", test_mem);

        // busy inputs during reset must not reach the outputs
        @(negedge clk);
        drive_random(3'b111, 3'b111);
        @(negedge clk);
        check_reset();
        $display("test reset : %s", test_errors == 0 ? "ok" : "mismatch");
        if (test_errors != 0) begin
            failed_tests++;
        end
        rst = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            drive_random(slave_sel_t'(test_mem[4*i]), slave_sel_t'(test_mem[4*i+1]));
            wk = int'(test_mem[4*i+2]);
            rk = int'(test_mem[4*i+3]);
            @(negedge clk);
            test_errors = 0;
            if (wk > IDLE_IDX || rk > IDLE_IDX) begin
                $display("test %0d: expected slave index out of range in the test file", i);
                errors++;
                test_errors++;
            end else begin
                check_write(wk);
                check_read(rk);
            end
            $display("test %0d wr_sel=%b rd_sel=%b : %s", i, wr_sel, rd_sel,
                     test_errors == 0 ? "ok" : "mismatch");
            if (test_errors != 0) begin
                failed_tests++;
            end
        end

        $display("%0d tests run, %0d with errors, %0d mismatches in total",
                 NUM_TESTS + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim/axi_xbar_tests.txt
// columns: wr_sel rd_sel expected_write_slave expected_read_slave (hex)
// a slave index of 3 means idle, no slave selected
1 1 0 0
2 2 1 1
4 4 2 2
1 2 0 1
2 4 1 2
4 1 2 0
0 0 3 3
3 5 0 0
6 6 1 1
5 3 0 0
7 7 0 0
0 1 3 0
2 0 1 3
4 0 2 3
0 4 3 2
6 2 1 1
3 6 0 1
5 4 0 2
7 0 0 3
0 7 3 0
1 4 0 2
2 1 1 0
4 2 2 1
0 0 3 3
6 5 1 0
5 6 0 1

// File: verilog/axi_read_router.sv
`timescale 1ns/10ps
`include "axi_xbar_defines.svh"

module axi_read_router import axi_xbar_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  slave_sel_t                        rd_sel,

    input  axi_ax_t                           m_ar,
    input  logic                              m_ar_valid,
    output logic                              m_ar_ready,
    output axi_r_t                            m_r,
    output logic                              m_r_valid,
    input  logic                              m_r_ready,

    output axi_ax_t [`AXI_XBAR_SLAVE_NUM-1:0] s_ar,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_ar_valid,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_ar_ready,
    input  axi_r_t  [`AXI_XBAR_SLAVE_NUM-1:0] s_r,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_r_valid,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_r_ready
);

    slave_idx_t rd_idx;
    logic       rd_hit;

    axi_ax_t [`AXI_XBAR_SLAVE_NUM-1:0] s_ar_d;
    logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_ar_valid_d;
    logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_r_ready_d;
    logic                              m_ar_ready_d;
    axi_r_t                            m_r_d;
    logic                              m_r_valid_d;

    assign rd_idx = first_slave(rd_sel);
    assign rd_hit = |rd_sel;

    always_comb begin
        s_ar_d       = '0;
        s_ar_valid_d = '0;
        s_r_ready_d  = '0;
        m_ar_ready_d = 1'b0;
        m_r_d        = '0;
        m_r_valid_d  = 1'b0;
        if (rd_hit) begin
            s_ar_d[rd_idx]       = m_ar;
            s_ar_valid_d[rd_idx] = m_ar_valid;
            // r_ready follows the data channel ready of the master
            s_r_ready_d[rd_idx]  = m_r_ready;
            m_ar_ready_d         = s_ar_ready[rd_idx];
            m_r_d                = s_r[rd_idx];
            m_r_valid_d          = s_r_valid[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_ar       <= '0;
            s_ar_valid <= '0;
            s_r_ready  <= '0;
            m_ar_ready <= 1'b0;
            m_r        <= '0;
            m_r_valid  <= 1'b0;
        end else begin
            s_ar       <= s_ar_d;
            s_ar_valid <= s_ar_valid_d;
            s_r_ready  <= s_r_ready_d;
            m_ar_ready <= m_ar_ready_d;
            m_r        <= m_r_d;
            m_r_valid  <= m_r_valid_d;
        end
    end

endmodule

// File: verilog/axi_write_router.sv
`timescale 1ns/10ps
`include "axi_xbar_defines.svh"

module axi_write_router import axi_xbar_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  slave_sel_t                        wr_sel,

    input  axi_ax_t                           m_aw,
    input  logic                              m_aw_valid,
    output logic                              m_aw_ready,
    input  axi_w_t                            m_w,
    input  logic                              m_w_valid,
    output logic                              m_w_ready,
    output axi_b_t                            m_b,
    output logic                              m_b_valid,
    input  logic                              m_b_ready,

    output axi_ax_t [`AXI_XBAR_SLAVE_NUM-1:0] s_aw,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_aw_valid,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_aw_ready,
    output axi_w_t  [`AXI_XBAR_SLAVE_NUM-1:0] s_w,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_w_valid,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_w_ready,
    input  axi_b_t  [`AXI_XBAR_SLAVE_NUM-1:0] s_b,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_b_valid,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_b_ready
);

    slave_idx_t wr_idx;
    logic       wr_hit;

    axi_ax_t [`AXI_XBAR_SLAVE_NUM-1:0] s_aw_d;
    logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_aw_valid_d;
    axi_w_t  [`AXI_XBAR_SLAVE_NUM-1:0] s_w_d;
    logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_w_valid_d;
    logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_b_ready_d;
    logic                              m_aw_ready_d;
    logic                              m_w_ready_d;
    axi_b_t                            m_b_d;
    logic                              m_b_valid_d;

    assign wr_idx = first_slave(wr_sel);
    assign wr_hit = |wr_sel;

    // everything not on the selected slave stays zero
    always_comb begin
        s_aw_d       = '0;
        s_aw_valid_d = '0;
        s_w_d        = '0;
        s_w_valid_d  = '0;
        s_b_ready_d  = '0;
        m_aw_ready_d = 1'b0;
        m_w_ready_d  = 1'b0;
        m_b_d        = '0;
        m_b_valid_d  = 1'b0;
        if (wr_hit) begin
            // forward to slave
            s_aw_d[wr_idx]       = m_aw;
            s_aw_valid_d[wr_idx] = m_aw_valid;
            s_w_d[wr_idx]        = m_w;
            s_w_valid_d[wr_idx]  = m_w_valid;
            s_b_ready_d[wr_idx]  = m_b_ready;
            // return to master
            m_aw_ready_d         = s_aw_ready[wr_idx];
            m_w_ready_d          = s_w_ready[wr_idx];
            m_b_d                = s_b[wr_idx];
            m_b_valid_d          = s_b_valid[wr_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_aw       <= '0;
            s_aw_valid <= '0;
            s_w        <= '0;
            s_w_valid  <= '0;
            s_b_ready  <= '0;
            m_aw_ready <= 1'b0;
            m_w_ready  <= 1'b0;
            m_b        <= '0;
            m_b_valid  <= 1'b0;
        end else begin
            s_aw       <= s_aw_d;
            s_aw_valid <= s_aw_valid_d;
            s_w        <= s_w_d;
            s_w_valid  <= s_w_valid_d;
            s_b_ready  <= s_b_ready_d;
            m_aw_ready <= m_aw_ready_d;
            m_w_ready  <= m_w_ready_d;
            m_b        <= m_b_d;
            m_b_valid  <= m_b_valid_d;
        end
    end

endmodule

// File: verilog/axi_xbar_defines.svh
`ifndef AXI_XBAR_DEFINES_SVH
`define AXI_XBAR_DEFINES_SVH

// slave ports behind the router
`define AXI_XBAR_SLAVE_NUM 3

// AXI4 field widths
`define AXI_ID_W    4
`define AXI_ADDR_W  64
`define AXI_DATA_W  64
`define AXI_STRB_W  8
`define AXI_LEN_W   8
`define AXI_SIZE_W  3
`define AXI_BURST_W 2
`define AXI_RESP_W  2

`endif

// File: verilog/axi_xbar_pkg.sv
`include "axi_xbar_defines.svh"

package axi_xbar_pkg;

    typedef logic [`AXI_ID_W-1:0]           axi_id_t;
    typedef logic [`AXI_ADDR_W-1:0]         axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0]         axi_data_t;
    typedef logic [`AXI_STRB_W-1:0]         axi_strb_t;
    typedef logic [`AXI_LEN_W-1:0]          axi_len_t;
    typedef logic [`AXI_SIZE_W-1:0]         axi_size_t;
    typedef logic [`AXI_BURST_W-1:0]        axi_burst_t;
    typedef logic [`AXI_RESP_W-1:0]         axi_resp_t;

    // one bit per slave and the lowest set bit wins
    typedef logic [`AXI_XBAR_SLAVE_NUM-1:0] slave_sel_t;

    localparam int SLAVE_IDX_W = $clog2(`AXI_XBAR_SLAVE_NUM);
    typedef logic [SLAVE_IDX_W-1:0]         slave_idx_t;

    // aw and ar share one payload layout
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    // priority decode scans downward so the lowest set bit is written last
    function automatic slave_idx_t first_slave(input slave_sel_t sel);
        slave_idx_t idx;
        idx = '0;
        for (int i = `AXI_XBAR_SLAVE_NUM - 1; i >= 0; i--) begin
            if (sel[i]) begin
                idx = slave_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

// File: verilog/axi_xbar_top.sv
`timescale 1ns/10ps
`include "axi_xbar_defines.svh"

module axi_xbar_top import axi_xbar_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  slave_sel_t                        wr_sel,
    input  slave_sel_t                        rd_sel,

    // master side
    input  axi_ax_t                           m_aw,
    input  logic                              m_aw_valid,
    output logic                              m_aw_ready,
    input  axi_w_t                            m_w,
    input  logic                              m_w_valid,
    output logic                              m_w_ready,
    output axi_b_t                            m_b,
    output logic                              m_b_valid,
    input  logic                              m_b_ready,
    input  axi_ax_t                           m_ar,
    input  logic                              m_ar_valid,
    output logic                              m_ar_ready,
    output axi_r_t                            m_r,
    output logic                              m_r_valid,
    input  logic                              m_r_ready,

    // slave side
    output axi_ax_t [`AXI_XBAR_SLAVE_NUM-1:0] s_aw,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_aw_valid,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_aw_ready,
    output axi_w_t  [`AXI_XBAR_SLAVE_NUM-1:0] s_w,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_w_valid,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_w_ready,
    input  axi_b_t  [`AXI_XBAR_SLAVE_NUM-1:0] s_b,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_b_valid,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_b_ready,
    output axi_ax_t [`AXI_XBAR_SLAVE_NUM-1:0] s_ar,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_ar_valid,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_ar_ready,
    input  axi_r_t  [`AXI_XBAR_SLAVE_NUM-1:0] s_r,
    input  logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_r_valid,
    output logic    [`AXI_XBAR_SLAVE_NUM-1:0] s_r_ready
);

    // write and read paths are independent
    axi_write_router u_write (
        .clk        (clk),
        .rst        (rst),
        .wr_sel     (wr_sel),
        .m_aw       (m_aw),
        .m_aw_valid (m_aw_valid),
        .m_aw_ready (m_aw_ready),
        .m_w        (m_w),
        .m_w_valid  (m_w_valid),
        .m_w_ready  (m_w_ready),
        .m_b        (m_b),
        .m_b_valid  (m_b_valid),
        .m_b_ready  (m_b_ready),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready),
        .s_b        (s_b),
        .s_b_valid  (s_b_valid),
        .s_b_ready  (s_b_ready)
    );

    axi_read_router u_read (
        .clk        (clk),
        .rst        (rst),
        .rd_sel     (rd_sel),
        .m_ar       (m_ar),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .m_r        (m_r),
        .m_r_valid  (m_r_valid),
        .m_r_ready  (m_r_ready),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready)
    );

endmodule
